// ==== Makefile ====
# Verilator flow for rv_core: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

# the log decides the result, the exit status of the run is ignored
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "sim: failure reported in $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "sim: no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
design/rv_pkg.sv
design/phase_sequencer.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_core.sv
dv/tb_rv_core.sv

// ==== design/decode_stage.sv ====
// decode_stage: instruction register, opcode/funct classification and immediate generation
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  rv_pkg::phase_e                     i_phase,
  input  wire logic [rv_pkg::INSN_BITS-1:0]  i_imem_rdata,
  output rv_pkg::decode_t                    o_dec
);

  localparam int EXT = rv_pkg::XLEN - 12;  // sign extension for 12-bit fields

  logic [rv_pkg::INSN_BITS-1:0] ir;        // instruction register
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [rv_pkg::XLEN-1:0]      imm_i;
  logic [rv_pkg::XLEN-1:0]      imm_s;
  logic [rv_pkg::XLEN-1:0]      imm_b;

  // imem data shows up during decode, grab it on the closing edge
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      ir <= '0;  // opcode 0 decodes as nop
    end
    else if (i_phase == rv_pkg::PH_DECODE)
    begin
      ir <= i_imem_rdata;
    end
  end

  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

  // i, s and b immediates
  assign imm_i = {{EXT{ir[31]}}, ir[31:20]};
  assign imm_s = {{EXT{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{(EXT-1){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};  // byte offset

  always_comb
  begin
    o_dec     = '0;
    o_dec.op  = rv_pkg::OP_NOP;
    o_dec.rd  = ir[11:7];   // meaningless for s/b, rf_we stays low there
    o_dec.rs1 = ir[19:15];
    o_dec.rs2 = ir[24:20];
    case (ir[6:0])
      rv_pkg::OPC_RTYPE:
      begin
        if (funct3 == rv_pkg::F3_ADD_SUB && funct7 == rv_pkg::F7_BASE)
          o_dec.op = rv_pkg::OP_ADD;
        else if (funct3 == rv_pkg::F3_ADD_SUB && funct7 == rv_pkg::F7_ALT)
          o_dec.op = rv_pkg::OP_SUB;
        else if (funct3 == rv_pkg::F3_AND && funct7 == rv_pkg::F7_BASE)
          o_dec.op = rv_pkg::OP_AND;
        else if (funct3 == rv_pkg::F3_OR && funct7 == rv_pkg::F7_BASE)
          o_dec.op = rv_pkg::OP_OR;
      end
      rv_pkg::OPC_ITYPE:
      begin
        o_dec.imm = imm_i;
        if (funct3 == rv_pkg::F3_ADD_SUB)
          o_dec.op = rv_pkg::OP_ADDI;
      end
      rv_pkg::OPC_LOAD:
      begin
        o_dec.imm = imm_i;
        if (funct3 == rv_pkg::F3_DOUBLE)
          o_dec.op = rv_pkg::OP_LD;
      end
      rv_pkg::OPC_STORE:
      begin
        o_dec.imm = imm_s;
        if (funct3 == rv_pkg::F3_DOUBLE)
          o_dec.op = rv_pkg::OP_SD;
      end
      rv_pkg::OPC_BRANCH:
      begin
        o_dec.imm = imm_b;
        if (funct3 == rv_pkg::F3_ADD_SUB)
          o_dec.op = rv_pkg::OP_BEQ;  // other branch kinds fall to nop
      end
      default:
      begin
        o_dec.op = rv_pkg::OP_NOP;  // unknown opcode, pc just steps
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// operand select, alu, beq compare and target, data memory strobe and exec register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  rv_pkg::phase_e                          i_phase,
  input  rv_pkg::decode_t                         i_dec,
  input  wire logic [rv_pkg::XLEN-1:0]            i_pc,
  input  wire logic [rv_pkg::XLEN-1:0]            i_rs1_data,
  input  wire logic [rv_pkg::XLEN-1:0]            i_rs2_data,
  output rv_pkg::exec_t                           o_exec,
  output logic                                    o_branch_taken,
  output logic [rv_pkg::XLEN-1:0]                 o_branch_target,
  output logic [rv_pkg::DMEM_ADDR_BITS-1:0]       o_dmem_addr,
  output logic                                    o_dmem_we,
  output logic [rv_pkg::XLEN-1:0]                 o_dmem_wdata
);

  logic                          use_imm;     // operand b from immediate
  logic                          writes_rd;
  logic                          beq_taken;
  logic [rv_pkg::XLEN-1:0]       operand_b;
  logic [rv_pkg::XLEN-1:0]       alu_result;
  logic [rv_pkg::XLEN-1:0]       result_q;
  logic [rv_pkg::REG_IDX_BITS-1:0] rd_q;
  logic                          load_q;
  logic                          rf_we_q;
  logic                          in_execute;

  assign in_execute = (i_phase == rv_pkg::PH_EXECUTE);
  assign use_imm    = i_dec.op inside {rv_pkg::OP_ADDI, rv_pkg::OP_LD, rv_pkg::OP_SD};
  assign writes_rd  = i_dec.op inside {rv_pkg::OP_ADD, rv_pkg::OP_SUB, rv_pkg::OP_AND,
                                       rv_pkg::OP_OR, rv_pkg::OP_ADDI, rv_pkg::OP_LD};
  assign operand_b  = use_imm ? i_dec.imm : i_rs2_data;

  // add covers addi and the ld/sd address
  always_comb
  begin
    case (i_dec.op)
      rv_pkg::OP_SUB: alu_result = i_rs1_data - operand_b;
      rv_pkg::OP_AND: alu_result = i_rs1_data & operand_b;
      rv_pkg::OP_OR:  alu_result = i_rs1_data | operand_b;
      default:        alu_result = i_rs1_data + operand_b;
    endcase
  end

  assign beq_taken = (i_dec.op == rv_pkg::OP_BEQ) && (i_rs1_data == i_rs2_data);

  // data port live during execute and the store strobe only there
  assign o_dmem_addr  = alu_result[rv_pkg::DMEM_ADDR_BITS+2:3];  // doubleword index
  assign o_dmem_wdata = i_rs2_data;
  assign o_dmem_we    = in_execute && (i_dec.op == rv_pkg::OP_SD);

  // execute boundary register, loaded on the edge closing execute
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      result_q        <= '0;
      rd_q            <= '0;
      load_q          <= 1'b0;
      rf_we_q         <= 1'b0;
      o_branch_taken  <= 1'b0;
      o_branch_target <= '0;
    end
    else if (in_execute)
    begin
      result_q        <= alu_result;
      rd_q            <= i_dec.rd;
      load_q          <= (i_dec.op == rv_pkg::OP_LD);
      rf_we_q         <= writes_rd;
      o_branch_taken  <= beq_taken;
      o_branch_target <= i_pc + i_dec.imm;  // pc still holds the beq address
    end
  end

  assign o_exec = '{result: result_q, rd: rd_q, is_load: load_q, rf_we: rf_we_q};

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
// fetch_stage: program counter, next-pc select and instruction word index
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  rv_pkg::phase_e                           i_phase,
  input  wire logic                                i_branch_taken,   // registered in execute
  input  wire logic [rv_pkg::XLEN-1:0]             i_branch_target,
  output logic [rv_pkg::XLEN-1:0]                  o_pc,
  output logic [rv_pkg::IMEM_ADDR_BITS-1:0]        o_imem_addr
);

  logic [rv_pkg::XLEN-1:0] pc_next;

  // taken beq wins, otherwise sequential
  assign pc_next = i_branch_taken ? i_branch_target : (o_pc + rv_pkg::PC_STEP);

  // pc only moves at the end of writeback, so it is stable for the whole instruction
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      o_pc <= '0;
    end
    else if (i_phase == rv_pkg::PH_WRITEBACK)
    begin
      o_pc <= pc_next;
    end
  end

  // word index, drops the byte offset
  assign o_imem_addr = o_pc[rv_pkg::IMEM_ADDR_BITS+1:2];

endmodule

`default_nettype wire

// ==== design/phase_sequencer.sv ====
// phase_sequencer: four-phase fetch/decode/execute/writeback stepper
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
  input  wire logic     clk,
  input  wire logic     reset,
  output rv_pkg::phase_e o_phase
);

  rv_pkg::phase_e phase_next;

  // strict round robin, no stalls since memories always answer in one cycle
  always_comb
  begin
    case (o_phase)
      rv_pkg::PH_FETCH:     phase_next = rv_pkg::PH_DECODE;
      rv_pkg::PH_DECODE:    phase_next = rv_pkg::PH_EXECUTE;
      rv_pkg::PH_EXECUTE:   phase_next = rv_pkg::PH_WRITEBACK;
      default:              phase_next = rv_pkg::PH_FETCH;  // back to fetch after wb
    endcase
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      o_phase <= rv_pkg::PH_FETCH;
    end
    else
    begin
      o_phase <= phase_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
// register_file: 32 x 64 integer registers, two combinational reads and one write
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                             clk,
  input  wire logic                             reset,
  input  wire logic [rv_pkg::REG_IDX_BITS-1:0]  i_rs1,
  input  wire logic [rv_pkg::REG_IDX_BITS-1:0]  i_rs2,
  input  wire logic [rv_pkg::REG_IDX_BITS-1:0]  i_rd,
  input  wire logic                             i_we,
  input  wire logic [rv_pkg::XLEN-1:0]          i_wdata,
  output logic [rv_pkg::XLEN-1:0]               o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]               o_rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::REG_COUNT];

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < rv_pkg::REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_we && (i_rd != '0))  // writes to x0 are dropped
    begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 forced to zero on read as well
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
// rv_core: top level wiring sequencer, stages and register file to the memory ports
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire logic                               clk,
  input  wire logic                               reset,
  output logic [rv_pkg::IMEM_ADDR_BITS-1:0]       o_imem_addr,
  input  wire logic [rv_pkg::INSN_BITS-1:0]       i_imem_rdata,
  output logic [rv_pkg::DMEM_ADDR_BITS-1:0]       o_dmem_addr,
  output logic                                    o_dmem_we,
  output logic [rv_pkg::XLEN-1:0]                 o_dmem_wdata,
  input  wire logic [rv_pkg::XLEN-1:0]            i_dmem_rdata
);

  rv_pkg::phase_e                  phase;
  rv_pkg::decode_t                 dec;
  rv_pkg::exec_t                   exec;
  logic [rv_pkg::XLEN-1:0]         pc;
  logic [rv_pkg::XLEN-1:0]         rs1_data;
  logic [rv_pkg::XLEN-1:0]         rs2_data;
  logic                            branch_taken;
  logic [rv_pkg::XLEN-1:0]         branch_target;
  logic [rv_pkg::REG_IDX_BITS-1:0] wb_rd;
  logic                            wb_we;
  logic [rv_pkg::XLEN-1:0]         wb_wdata;

  phase_sequencer u_seq (
    .clk     (clk),
    .reset   (reset),
    .o_phase (phase)
  );

  fetch_stage u_fetch (
    .clk             (clk),
    .reset           (reset),
    .i_phase         (phase),
    .i_branch_taken  (branch_taken),
    .i_branch_target (branch_target),
    .o_pc            (pc),
    .o_imem_addr     (o_imem_addr)
  );

  decode_stage u_decode (
    .clk          (clk),
    .reset        (reset),
    .i_phase      (phase),
    .i_imem_rdata (i_imem_rdata),
    .o_dec        (dec)
  );

  register_file u_rf (
    .clk        (clk),
    .reset      (reset),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .i_rd       (wb_rd),
    .i_we       (wb_we),
    .i_wdata    (wb_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  execute_stage u_exec (
    .clk             (clk),
    .reset           (reset),
    .i_phase         (phase),
    .i_dec           (dec),
    .i_pc            (pc),
    .i_rs1_data      (rs1_data),
    .i_rs2_data      (rs2_data),
    .o_exec          (exec),
    .o_branch_taken  (branch_taken),
    .o_branch_target (branch_target),
    .o_dmem_addr     (o_dmem_addr),
    .o_dmem_we       (o_dmem_we),
    .o_dmem_wdata    (o_dmem_wdata)
  );

  writeback_stage u_wb (
    .i_phase      (phase),
    .i_exec       (exec),
    .i_dmem_rdata (i_dmem_rdata),
    .o_rd         (wb_rd),
    .o_rf_we      (wb_we),
    .o_rf_wdata   (wb_wdata)
  );

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
// widths, funct field codes, phase/opcode/op enums and the decode and execute stage structs
`default_nettype none

package rv_pkg;

  // datapath and memory geometry
  localparam int XLEN           = 64;   // data and pc width
  localparam int INSN_BITS      = 32;
  localparam int REG_COUNT      = 32;
  localparam int REG_IDX_BITS   = 5;
  localparam int IMEM_ADDR_BITS = 6;    // word index into instruction memory
  localparam int DMEM_ADDR_BITS = 6;    // doubleword index into data memory

  localparam logic [XLEN-1:0] PC_STEP = 64'd4;  // one 32-bit word per instruction

  // funct3 values for the kept instructions
  localparam logic [2:0] F3_ADD_SUB = 3'b000;   // add, sub, addi, beq
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_DOUBLE  = 3'b011;   // ld / sd width code

  // funct7 values for r-type
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub

  // one instruction walks through these in order
  typedef enum logic [1:0] {
    PH_FETCH     = 2'd0,
    PH_DECODE    = 2'd1,
    PH_EXECUTE   = 2'd2,
    PH_WRITEBACK = 2'd3
  } phase_e;

  // major opcode field, insn[6:0]
  typedef enum logic [6:0] {
    OPC_RTYPE  = 7'b0110011,
    OPC_ITYPE  = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // decoded operation, anything unknown lands on OP_NOP
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_ADDI = 4'd4,
    OP_LD   = 4'd5,
    OP_SD   = 4'd6,
    OP_BEQ  = 4'd7,
    OP_NOP  = 4'd8
  } op_e;

  // decode -> execute
  typedef struct packed {
    op_e                     op;
    logic [REG_IDX_BITS-1:0] rd;
    logic [REG_IDX_BITS-1:0] rs1;
    logic [REG_IDX_BITS-1:0] rs2;
    logic [XLEN-1:0]         imm;   // already sign extended
  } decode_t;

  // execute -> writeback
  typedef struct packed {
    logic [XLEN-1:0]         result;   // alu result, also the load/store address
    logic [REG_IDX_BITS-1:0] rd;
    logic                    is_load;  // take write data from dmem
    logic                    rf_we;    // op writes rd
  } exec_t;

endpackage

`default_nettype wire

// ==== design/writeback_stage.sv ====
// writeback_stage: register-file write data select and write enable
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  rv_pkg::phase_e                        i_phase,
  input  rv_pkg::exec_t                         i_exec,
  input  wire logic [rv_pkg::XLEN-1:0]          i_dmem_rdata,   // ld data arrives in wb
  output logic [rv_pkg::REG_IDX_BITS-1:0]       o_rd,
  output logic                                  o_rf_we,
  output logic [rv_pkg::XLEN-1:0]               o_rf_wdata
);

  assign o_rd = i_exec.rd;

  // rf takes the write on the edge closing writeback
  assign o_rf_we = (i_phase == rv_pkg::PH_WRITEBACK) && i_exec.rf_we;

  // load data or alu result
  assign o_rf_wdata = i_exec.is_load ? i_dmem_rdata : i_exec.result;

endmodule

`default_nettype wire

// ==== dv/program_vectors.txt ====
# records: I insn_word | D dmem_index value | S store_index store_data | F fetch_index
# all hex; I words fill imem from index 0, S and F records are in program order
I 00003083  I 00803103  I 002081b3  I 04303023   # ld x1,0 / ld x2,8 / add x3 / sd x3,64
I 40208233  I 04403423  I 0020f2b3  I 04503823   # sub x4 / sd x4,72 / and x5 / sd x5,80
I 0020e333  I 04603c23  I 06400393  I ffd38413   # or x6 / sd x6,88 / addi x7,100 / addi x8,-3
I 06803023  I 00500013  I 06003423  I 01003483   # sd x8,96 / addi x0,5 / sd x0,104 / ld x9,16
I 06903823  I 00208463  I 00738663  I 06703c23   # sd x9,112 / beq x1,x2 / beq x7,x7 / sd x7,120
I 06803c23  I 08703023  I 0000000b  I 08303423   # sd x8,120 / sd x7,128 / nop / sd x3,136
D 00 123456789abcdef0
D 01 0f0f0f0ff0f0f0f0
D 02 deadbeefcafef00d
S 08 214365888badcfe0   # add
S 09 03254768a9cbee00   # sub
S 0a 0204060890b0d0f0   # and
S 0b 1f3f5f7ffafcfef0   # or
S 0c 0000000000000061   # 100 - 3
S 0d 0000000000000000   # x0 after a write attempt
S 0e deadbeefcafef00d   # ld then sd copy
S 10 0000000000000064   # index 0f skipped by taken beq
S 11 214365888badcfe0   # x3 untouched by the nop
F 00  F 01  F 02  F 03  F 04  F 05  F 06  F 07
F 08  F 09  F 0a  F 0b  F 0c  F 0d  F 0e  F 0f
F 10  F 11  F 12  F 15  F 16  F 17  F 18   # beq at 11 falls through, beq at 12 jumps to 15

// ==== dv/tb_rv_core.sv ====
// rv_core testbench with memory models, vector file loading, fetch and store checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int    CLK_PERIOD      = 4;
  localparam int    RESET_CYCLES    = 10;
  localparam int    CYCLES_PER_INSN = 4;   // fetch, decode, execute, writeback
  localparam int    IMEM_WORDS      = 1 << rv_pkg::IMEM_ADDR_BITS;
  localparam int    DMEM_WORDS      = 1 << rv_pkg::DMEM_ADDR_BITS;
  localparam string VECTOR_FILE     = "dv/program_vectors.txt";

  // one expected sd as index plus doubleword
  typedef struct packed {
    logic [rv_pkg::DMEM_ADDR_BITS-1:0] addr;
    logic [rv_pkg::XLEN-1:0]           data;
  } store_rec_t;

  logic                              clk;
  logic                              reset;
  logic [rv_pkg::IMEM_ADDR_BITS-1:0] imem_addr;
  logic [rv_pkg::INSN_BITS-1:0]      imem_rdata = '0;
  logic [rv_pkg::DMEM_ADDR_BITS-1:0] dmem_addr;
  logic                              dmem_we;
  logic [rv_pkg::XLEN-1:0]           dmem_wdata;
  logic [rv_pkg::XLEN-1:0]           dmem_rdata = '0;

  logic [rv_pkg::INSN_BITS-1:0]      imem [IMEM_WORDS];
  logic [rv_pkg::XLEN-1:0]           dmem [DMEM_WORDS];

  logic [rv_pkg::IMEM_ADDR_BITS-1:0] exp_fetch [$];   // in program order
  store_rec_t                        exp_stores [$];
  store_rec_t                        next_store;
  logic [rv_pkg::IMEM_ADDR_BITS-1:0] last_fetch;
  int                                fetch_total = 0;
  int                                cycles_since_fetch = 0;
  int                                seed = 32'hb75e;
  bit                                fetch_seen = 1'b0;
  bit                                fetch_done = 1'b0;
  bit                                vectors_loaded = 1'b0;

  rv_core UUT (
    .clk          (clk),
    .reset        (reset),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one-cycle synchronous memories returning the pre-write word
  always @(posedge clk)
  begin
    imem_rdata <= imem[imem_addr];
    if (dmem_we === 1'b1)
      dmem[dmem_addr] <= dmem_wdata;
    dmem_rdata <= dmem[dmem_addr];
  end

  task automatic stop_with_failure();
    begin
      $display("SIMULATION FAILED");
      $fatal(1, "run aborted");
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    begin
      if (actual !== expected)
      begin
        $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        stop_with_failure();
      end
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          words;
    logic [7:0]  kind;
    logic [63:0] idx;
    logic [63:0] val;
    string       rest;
    store_rec_t  rec;
    bit          bad_kind;
    bit          bad_field;
    begin
      words     = 0;
      bad_kind  = 1'b0;
      bad_field = 1'b0;
      for (int i = 0; i < IMEM_WORDS; i++)
        imem[i[rv_pkg::IMEM_ADDR_BITS-1:0]] = {i[24:0], 7'h00};  // opcode 0 runs as nop
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i[rv_pkg::DMEM_ADDR_BITS-1:0]] = {$random(seed), $random(seed)};
      fd = $fopen(VECTOR_FILE, "r");
      if (fd == 0)
      begin
        $display("cannot open vector file %s", VECTOR_FILE);
        stop_with_failure();
      end
      else
      begin
        while (!bad_kind && !bad_field && $fscanf(fd, " %c", kind) == 1)
        begin
          case (kind)
            "#": code = $fgets(rest, fd);   // comment to end of line
            "I":
            begin
              code = $fscanf(fd, "%h", val);
              bad_field = (code != 1);
              imem[words[rv_pkg::IMEM_ADDR_BITS-1:0]] = val[rv_pkg::INSN_BITS-1:0];
              words++;
            end
            "D":
            begin
              code = $fscanf(fd, "%h %h", idx, val);
              bad_field = (code != 2);
              dmem[idx[rv_pkg::DMEM_ADDR_BITS-1:0]] = val;
            end
            "S":
            begin
              code = $fscanf(fd, "%h %h", idx, val);
              bad_field = (code != 2);
              rec.addr = idx[rv_pkg::DMEM_ADDR_BITS-1:0];
              rec.data = val;
              exp_stores.push_back(rec);
            end
            "F":
            begin
              code = $fscanf(fd, "%h", idx);
              bad_field = (code != 1);
              exp_fetch.push_back(idx[rv_pkg::IMEM_ADDR_BITS-1:0]);
            end
            default: bad_kind = 1'b1;
          endcase
        end
        $fclose(fd);
        if (bad_kind)
        begin
          $display("unknown record kind '%c' in %s", kind, VECTOR_FILE);
          stop_with_failure();
        end
        else if (bad_field)
        begin
          $display("record '%c' in %s has missing or unreadable fields", kind, VECTOR_FILE);
          stop_with_failure();
        end
        else
        begin
          fetch_total    = exp_fetch.size();
          vectors_loaded = 1'b1;
        end
      end
    end
  endtask

  // fetch index sampled mid-cycle and each change must be the next F record
  always @(negedge clk)
  begin
    if (reset && vectors_loaded && !fetch_done)
    begin
      cycles_since_fetch++;
      if (!fetch_seen || imem_addr != last_fetch)
      begin
        if (fetch_seen)
          check_value("fetch_interval", 64'(cycles_since_fetch), 64'(CYCLES_PER_INSN));
        check_value("o_imem_addr", 64'(imem_addr), 64'(exp_fetch.pop_front()));
        last_fetch         = imem_addr;
        fetch_seen         = 1'b1;
        cycles_since_fetch = 0;
        if (exp_fetch.size() == 0)
          fetch_done = 1'b1;
      end
    end
  end

  // every strobe must line up with the next S record
  always @(negedge clk)
  begin
    if (dmem_we === 1'b1 && !fetch_done)
    begin
      if (exp_stores.size() == 0)
      begin
        $display("store strobe at index %h with no expected store left", dmem_addr);
        stop_with_failure();
      end
      else
      begin
        next_store = exp_stores.pop_front();
        check_value("o_dmem_addr", 64'(dmem_addr), 64'(next_store.addr));
        check_value("o_dmem_wdata", dmem_wdata, next_store.data);
      end
    end
  end

  initial
  begin
    wait (vectors_loaded);
    #(CLK_PERIOD * CYCLES_PER_INSN * (fetch_total + 8));
    $display("timeout: fetch sequence not finished, %0d fetch records left", exp_fetch.size());
    stop_with_failure();
  end

  initial
  begin
    reset = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b1;
    wait (fetch_done);
    @(negedge clk);
    check_value("stores_left", 64'(exp_stores.size()), 64'd0);  // skipped sd must not strobe
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
